// ==== src.f ====
conv_pkg.sv
conv_decode.sv
conv_mac.sv
conv_mac_array.sv
conv_result.sv
conv_engine.sv
tb_conv_engine.sv

// ==== run.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it, the exit status tells pass or fail
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_conv_engine -f src.f
./obj_dir/Vtb_conv_engine

// ==== tb_conv_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_conv_engine
  import conv_pkg::*;
();

  localparam int MEMBERS     = 4;
  localparam int UNITS       = 2;
  localparam int LATENCY_MUL = 2;
  localparam int WAIT_LIMIT  = 60;
  localparam int NUM_ROWS    = 11;
  localparam logic [1:0] MODE_RANDOM = 2'd0;
  localparam logic [1:0] MODE_MIN    = 2'd1;
  localparam logic [1:0] MODE_MAX    = 2'd2;
  localparam logic [1:0] MODE_MIXED  = 2'd3;

  typedef acc_t [MEMBERS-1:0][UNITS-1:0] sums_t;

  // a row holds the beat counts, clken-low cycles, data mode, chaining and flags of one group
  typedef struct packed {
    logic [3:0] beats;
    logic [3:0] idle_after_first;
    logic [3:0] clk_off;
    logic [1:0] data_mode;
    logic       back_to_back;
    logic       last;
    out_user_t  user;
  } row_t;

  logic clk;
  logic rst;
  logic clken;
  logic s_valid;
  logic s_last;
  logic m_valid;
  logic m_last;
  conv_user_t s_user;
  pixel_t  [UNITS-1:0] s_pixels;
  weight_t [MEMBERS-1:0] s_weights;
  out_user_t m_user;
  sums_t m_data;

  row_t rows [NUM_ROWS];
  sums_t exp_data_q [$];
  logic exp_last_q [$];
  out_user_t exp_user_q [$];
  int groups_sent;
  int pulses_seen;
  logic [31:0] rng_state;

  conv_engine #(
    .MEMBERS     (MEMBERS),
    .UNITS       (UNITS),
    .LATENCY_MUL (LATENCY_MUL)
  ) dut_i (
    .clk       (clk),
    .rst       (rst),
    .clken     (clken),
    .s_valid   (s_valid),
    .s_last    (s_last),
    .s_user    (s_user),
    .s_pixels  (s_pixels),
    .s_weights (s_weights),
    .m_valid   (m_valid),
    .m_last    (m_last),
    .m_user    (m_user),
    .m_data    (m_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // --------------------------------------------------
  // random data and checks
  // --------------------------------------------------

  function automatic logic [7:0] next_byte();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state[7:0];
  endfunction

  function automatic pixel_t pick_word(input logic [1:0] mode);
    logic [7:0] r;
    r = next_byte();
    case (mode)
      MODE_MIN: return pixel_t'(8'h80);
      MODE_MAX: return pixel_t'(8'h7f);
      MODE_MIXED: return r[0] ? pixel_t'(8'h7f) : pixel_t'(8'h80);
      default: return pixel_t'(r);
    endcase
  endfunction

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_acc(input string name, input acc_t got, input acc_t exp);
    if (got !== exp) begin
      fail_stop($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_user(input string name, input out_user_t got, input out_user_t exp);
    if (got !== exp) begin
      fail_stop($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_stop($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // outputs are stable mid-cycle, away from the edge where inputs change
  always @(negedge clk) begin : output_monitor
    sums_t exp_data;
    if (!rst && m_valid) begin
      if (!clken) begin
        fail_stop("m_valid was high while clken was low");
      end else if (exp_data_q.size() == 0) begin
        fail_stop("m_valid pulsed with no group pending");
      end else begin
        exp_data = exp_data_q.pop_front();
        for (int m = 0; m < MEMBERS; m++) begin
          for (int u = 0; u < UNITS; u++) begin
            check_acc($sformatf("m_data[%0d][%0d]", m, u), m_data[m][u], exp_data[m][u]);
          end
        end
        check_flag("m_last", m_last, exp_last_q.pop_front());
        check_user("m_user", m_user, exp_user_q.pop_front());
        pulses_seen++;
      end
    end else if (!rst) begin
      check_flag("m_last", m_last, 1'b0);
    end
  end

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------

  task automatic drive_beat(input logic en, input logic v, input logic cin_last,
                            input logic last, input out_user_t user, input logic [1:0] mode,
                            output pixel_t [UNITS-1:0] px, output weight_t [MEMBERS-1:0] wt);
    for (int u = 0; u < UNITS; u++) begin
      px[u] = pick_word(mode);
    end
    for (int m = 0; m < MEMBERS; m++) begin
      wt[m] = weight_t'(pick_word(mode));
    end
    @(posedge clk);
    clken     <= en;
    s_valid   <= v;
    s_last    <= last;
    s_user    <= '{out_user: user, is_cin_last: cin_last, kernel_w_1: '0};
    s_pixels  <= px;
    s_weights <= wt;
  endtask

  task automatic run_group(input row_t r);
    pixel_t  [UNITS-1:0]   px;
    weight_t [MEMBERS-1:0] wt;
    sums_t                 exp_data;
    logic [7:0]            noise;
    exp_data = '0;
    for (int b = 0; b < int'(r.beats); b++) begin
      noise = next_byte();
      if (b == int'(r.beats) - 1) begin
        groups_sent++;
        drive_beat(1'b1, 1'b1, 1'b1, r.last, r.user, r.data_mode, px, wt);
      end else begin
        // early beats carry noise in last and user since only the closing beat counts
        drive_beat(1'b1, 1'b1, 1'b0, noise[4], out_user_t'(noise[3:0]), r.data_mode, px, wt);
      end
      for (int m = 0; m < MEMBERS; m++) begin
        for (int u = 0; u < UNITS; u++) begin
          exp_data[m][u] = exp_data[m][u] + acc_t'(px[u]) * acc_t'(wt[m]);
        end
      end
      if (b == 0) begin
        repeat (int'(r.idle_after_first)) drive_beat(1'b1, 1'b0, 1'b1, 1'b1, 4'hf, 2'd0, px, wt);
        // a frozen pipeline must ignore even a valid closing beat
        repeat (int'(r.clk_off)) drive_beat(1'b0, 1'b1, 1'b1, 1'b1, 4'hf, 2'd0, px, wt);
      end
    end
    exp_data_q.push_back(exp_data);
    exp_last_q.push_back(r.last);
    exp_user_q.push_back(r.user);
    repeat (int'(r.clk_off)) drive_beat(1'b0, 1'b1, 1'b1, 1'b1, 4'hf, 2'd0, px, wt);
  endtask

  task automatic wait_results();
    int cycles;
    cycles = 0;
    while (pulses_seen != groups_sent) begin
      if (cycles >= WAIT_LIMIT) begin
        fail_stop("timed out waiting for m_valid");
      end else begin
        @(posedge clk);
        cycles++;
      end
    end
  endtask

  initial begin : stimulus
    pixel_t  [UNITS-1:0]   px;
    weight_t [MEMBERS-1:0] wt;
    rng_state = 32'h265ec592;
    groups_sent = 0;
    pulses_seen = 0;
    {rst, clken, s_valid, s_last} = 4'b1000;
    s_user = '0;
    s_pixels = '0;
    s_weights = '0;
    rows[0]  = '{4'd1, 4'd0, 4'd0, MODE_RANDOM, 1'b0, 1'b0, 4'h1};
    rows[1]  = '{4'd4, 4'd0, 4'd0, MODE_RANDOM, 1'b0, 1'b1, 4'ha};
    rows[2]  = '{4'd3, 4'd0, 4'd0, MODE_MIN,    1'b0, 1'b0, 4'hf};
    rows[3]  = '{4'd5, 4'd0, 4'd0, MODE_MAX,    1'b0, 1'b1, 4'h5};
    rows[4]  = '{4'd6, 4'd0, 4'd0, MODE_MIXED,  1'b0, 1'b0, 4'h3};
    rows[5]  = '{4'd3, 4'd0, 4'd0, MODE_RANDOM, 1'b1, 1'b0, 4'h6};
    rows[6]  = '{4'd1, 4'd0, 4'd0, MODE_MIXED,  1'b1, 1'b1, 4'h9};
    rows[7]  = '{4'd2, 4'd0, 4'd0, MODE_RANDOM, 1'b0, 1'b1, 4'h2};
    rows[8]  = '{4'd4, 4'd3, 4'd0, MODE_RANDOM, 1'b0, 1'b0, 4'h7};
    rows[9]  = '{4'd1, 4'd2, 4'd3, MODE_MIXED,  1'b0, 1'b1, 4'h4};
    rows[10] = '{4'd8, 4'd1, 4'd2, MODE_MIXED,  1'b0, 1'b1, 4'hb};
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_group(rows[i]);
      if (!rows[i].back_to_back) begin
        drive_beat(1'b1, 1'b0, 1'b0, 1'b0, 4'h0, 2'd0, px, wt);
        wait_results();
      end
    end
    // stray pulses would show up here as a group with nothing pending
    repeat (4 * (LATENCY_MUL + 3)) @(posedge clk);
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== conv_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_engine
  import conv_pkg::*;
#(
  parameter int MEMBERS     = 4,
  parameter int UNITS       = 2,
  parameter int LATENCY_MUL = 2
) (
  input  wire logic                             clk,
  input  wire logic                             rst,
  input  wire logic                             clken,
  input  wire logic                             s_valid,
  input  wire logic                             s_last,
  input  wire conv_user_t                       s_user,
  input  wire pixel_t  [UNITS-1:0]              s_pixels,
  input  wire weight_t [MEMBERS-1:0]            s_weights,
  output logic                                  m_valid,
  output logic                                  m_last,
  output out_user_t                             m_user,
  output acc_t      [MEMBERS-1:0][UNITS-1:0]    m_data
);

  beat_ctrl_t                       dec_ctrl;
  pixel_t  [UNITS-1:0]              dec_pixels;
  weight_t [MEMBERS-1:0]            dec_weights;
  beat_ctrl_t                       acc_ctrl;
  acc_t    [MEMBERS-1:0][UNITS-1:0] acc_data;

  conv_decode #(
    .MEMBERS (MEMBERS),
    .UNITS   (UNITS)
  ) decode_i (
    .clk         (clk),
    .rst         (rst),
    .clken       (clken),
    .s_valid     (s_valid),
    .s_last      (s_last),
    .s_user      (s_user),
    .s_pixels    (s_pixels),
    .s_weights   (s_weights),
    .dec_ctrl    (dec_ctrl),
    .dec_pixels  (dec_pixels),
    .dec_weights (dec_weights)
  );

  conv_mac_array #(
    .MEMBERS     (MEMBERS),
    .UNITS       (UNITS),
    .LATENCY_MUL (LATENCY_MUL)
  ) mac_array_i (
    .clk         (clk),
    .rst         (rst),
    .clken       (clken),
    .dec_ctrl    (dec_ctrl),
    .dec_pixels  (dec_pixels),
    .dec_weights (dec_weights),
    .acc_ctrl    (acc_ctrl),
    .acc_data    (acc_data)
  );

  conv_result #(
    .MEMBERS (MEMBERS),
    .UNITS   (UNITS)
  ) result_i (
    .clk      (clk),
    .rst      (rst),
    .clken    (clken),
    .acc_ctrl (acc_ctrl),
    .acc_data (acc_data),
    .m_valid  (m_valid),
    .m_last   (m_last),
    .m_user   (m_user),
    .m_data   (m_data)
  );

endmodule

`default_nettype wire

// ==== conv_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_result
  import conv_pkg::*;
#(
  parameter int MEMBERS = 4,
  parameter int UNITS   = 2
) (
  input  wire logic                             clk,
  input  wire logic                             rst,
  input  wire logic                             clken,
  input  wire beat_ctrl_t                       acc_ctrl,
  input  wire acc_t [MEMBERS-1:0][UNITS-1:0]    acc_data,
  output logic                                  m_valid,
  output logic                                  m_last,
  output out_user_t                             m_user,
  output acc_t      [MEMBERS-1:0][UNITS-1:0]    m_data
);

  logic group_done;
  logic valid_q;
  logic last_q;

  // the sums are complete once the cin_last beat has left the accumulators
  assign group_done = acc_ctrl.valid && acc_ctrl.cin_last;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else if (clken) begin
      valid_q <= group_done;
      last_q  <= group_done && acc_ctrl.last;
    end
  end

  always_ff @(posedge clk) begin
    if (clken && group_done) begin
      m_data <= acc_data;
      m_user <= acc_ctrl.user;
    end
  end

  // a frozen pipeline shows no pulse and the pending one appears when clken returns
  assign m_valid = valid_q && clken;
  assign m_last  = last_q && clken;

  // --------------------------------------------------
  // output checks
  // --------------------------------------------------

  last_needs_valid : assert property (
    @(posedge clk) disable iff (rst)
    m_last |-> m_valid
  ) else $error("m_last without m_valid");

  // two pulses in a row only when the second group is a single fresh beat
  single_pulse : assert property (
    @(posedge clk) disable iff (rst)
    (m_valid && !(group_done && acc_ctrl.bypass)) |=> !m_valid
  ) else $error("m_valid held for two clocks");

endmodule

`default_nettype wire

// ==== conv_mac_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_mac_array
  import conv_pkg::*;
#(
  parameter int MEMBERS     = 4,
  parameter int UNITS       = 2,
  parameter int LATENCY_MUL = 2
) (
  input  wire logic                          clk,
  input  wire logic                          rst,
  input  wire logic                          clken,
  input  wire beat_ctrl_t                    dec_ctrl,
  input  wire pixel_t  [UNITS-1:0]           dec_pixels,
  input  wire weight_t [MEMBERS-1:0]         dec_weights,
  output beat_ctrl_t                         acc_ctrl,
  output acc_t         [MEMBERS-1:0][UNITS-1:0] acc_data
);

  // --------------------------------------------------
  // control delay line
  // --------------------------------------------------

  // stage LATENCY_MUL-1 lines up with the products, the last one with the sums
  beat_ctrl_t ctrl_pipe [LATENCY_MUL+1];
  beat_ctrl_t mul_ctrl;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i <= LATENCY_MUL; i++) begin
        ctrl_pipe[i] <= '0;
      end
    end else if (clken) begin
      ctrl_pipe[0] <= dec_ctrl;
      for (int i = 1; i <= LATENCY_MUL; i++) begin
        ctrl_pipe[i] <= ctrl_pipe[i-1];
      end
    end
  end

  assign mul_ctrl = ctrl_pipe[LATENCY_MUL-1];
  assign acc_ctrl = ctrl_pipe[LATENCY_MUL];

  // --------------------------------------------------
  // lane grid
  // --------------------------------------------------

  // pixel u goes to every member and weight m to every unit
  for (genvar m = 0; m < MEMBERS; m++) begin : g_member
    for (genvar u = 0; u < UNITS; u++) begin : g_unit
      conv_mac #(
        .LATENCY_MUL (LATENCY_MUL)
      ) mac_i (
        .clk    (clk),
        .rst    (rst),
        .clken  (clken),
        .pixel  (dec_pixels[u]),
        .weight (dec_weights[m]),
        .valid  (mul_ctrl.valid),
        .bypass (mul_ctrl.bypass),
        .sum    (acc_data[m][u])
      );
    end
  end

endmodule

`default_nettype wire

// ==== conv_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_mac
  import conv_pkg::*;
#(
  parameter int LATENCY_MUL = 2
) (
  input  wire logic    clk,
  input  wire logic    rst,
  input  wire logic    clken,
  input  wire pixel_t  pixel,
  input  wire weight_t weight,
  input  wire logic    valid,
  input  wire logic    bypass,
  output acc_t         sum
);

  // --------------------------------------------------
  // multiplier pipeline
  // --------------------------------------------------

  product_t mul_pipe [LATENCY_MUL];

  always_ff @(posedge clk) begin
    if (clken) begin
      mul_pipe[0] <= pixel * weight;
      for (int i = 1; i < LATENCY_MUL; i++) begin
        mul_pipe[i] <= mul_pipe[i-1];
      end
    end
  end

  // --------------------------------------------------
  // accumulator
  // --------------------------------------------------

  product_t product_masked;
  acc_t     addend;

  // an empty beat contributes nothing to the running sum
  assign product_masked = valid ? mul_pipe[LATENCY_MUL-1] : '0;

  // sign extension up to the accumulator width
  assign addend = acc_t'(product_masked);

  always_ff @(posedge clk) begin
    if (rst) begin
      sum <= '0;
    end else if (clken) begin
      if (bypass) begin
        sum <= addend;
      end else begin
        sum <= sum + addend;
      end
    end
  end

endmodule

`default_nettype wire

// ==== conv_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module conv_decode
  import conv_pkg::*;
#(
  parameter int MEMBERS = 4,
  parameter int UNITS   = 2
) (
  input  wire logic                      clk,
  input  wire logic                      rst,
  input  wire logic                      clken,
  input  wire logic                      s_valid,
  input  wire logic                      s_last,
  input  wire conv_user_t                s_user,
  input  wire pixel_t  [UNITS-1:0]       s_pixels,
  input  wire weight_t [MEMBERS-1:0]     s_weights,
  output beat_ctrl_t                     dec_ctrl,
  output pixel_t       [UNITS-1:0]       dec_pixels,
  output weight_t      [MEMBERS-1:0]     dec_weights
);

  // high while a group has taken valid beats but not yet its cin_last beat
  logic group_open;

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_ctrl   <= '0;
      group_open <= 1'b0;
    end else if (clken) begin
      dec_ctrl.valid    <= s_valid;
      dec_ctrl.last     <= s_last;
      dec_ctrl.cin_last <= s_user.is_cin_last;
      dec_ctrl.user     <= s_user.out_user;
      // the first valid beat of a group loads the accumulators fresh
      dec_ctrl.bypass   <= s_valid && !group_open;
      if (s_valid) begin
        group_open <= !s_user.is_cin_last;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (clken) begin
      dec_pixels  <= s_pixels;
      dec_weights <= s_weights;
    end
  end

  // only 1x1 kernels are handled by this engine
  kernel_w_is_one : assert property (
    @(posedge clk) disable iff (rst)
    (clken && s_valid) |-> (s_user.kernel_w_1 == '0)
  ) else $error("kernel_w_1 is not zero on a valid beat");

endmodule

`default_nettype wire

// ==== conv_pkg.sv ====
`default_nettype none

package conv_pkg;

  // --------------------------------------------------
  // word widths
  // --------------------------------------------------

  localparam int WORD_WIDTH     = 8;
  localparam int WORD_WIDTH_ACC = 32;
  localparam int BITS_KERNEL_W  = 3;

  typedef logic signed [WORD_WIDTH-1:0]     pixel_t;
  typedef logic signed [WORD_WIDTH-1:0]     weight_t;
  typedef logic signed [2*WORD_WIDTH-1:0]   product_t;
  typedef logic signed [WORD_WIDTH_ACC-1:0] acc_t;

  // --------------------------------------------------
  // control structs
  // --------------------------------------------------

  // flags that ride along with a group and leave with its sums
  typedef struct packed {
    logic is_max;
    logic is_lrelu;
    logic is_top_block;
    logic is_bottom_block;
  } out_user_t;

  // layout of the s_user input word
  typedef struct packed {
    out_user_t                out_user;
    logic                     is_cin_last;
    logic [BITS_KERNEL_W-1:0] kernel_w_1;
  } conv_user_t;

  // per-beat control once the user word has been unpacked
  typedef struct packed {
    logic      valid;
    logic      last;
    logic      cin_last;
    logic      bypass;
    out_user_t user;
  } beat_ctrl_t;

endpackage

`default_nettype wire
